//--- source/rab_pkg.sv
package rab_pkg;

  // address split into a 4 KiB page number and an in-page offset
  localparam int ADDR_W = 32;
  localparam int OFFS_W = 12;
  localparam int PAGE_W = ADDR_W - OFFS_W;

  // AW channel field widths
  localparam int ID_W    = 4;
  localparam int USER_W  = 4;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int PROT_W  = 3;

  // table sizes, the configuration index covers the larger one
  localparam int L1_ENTRIES = 4;
  localparam int L2_ENTRIES = 8;
  localparam int IDX_W      = 3;

  // why a request was dropped
  typedef enum logic [1:0] {
    FLT_L1_PROT = 2'd0,
    FLT_L1_MISS = 2'd1,
    FLT_L2_PROT = 2'd2,
    FLT_L2_MISS = 2'd3
  } fault_cause_e;

endpackage

//--- source/rab_l1_tlb.sv
`timescale 1ns/10ps

module rab_l1_tlb
  import rab_pkg::*;
#(
  parameter bit ENABLE_L2TLB = 1'b1
) (
  input  logic              axi4_aclk,
  input  logic              axi4_arstn,
  input  logic              cfg_we_i,
  input  logic              cfg_l2_i,
  input  logic [IDX_W-1:0]  cfg_idx_i,
  input  logic [PAGE_W-1:0] cfg_vpn_i,
  input  logic [PAGE_W-1:0] cfg_ppn_i,
  input  logic              cfg_wr_ok_i,
  input  logic              cfg_valid_i,
  input  logic [ADDR_W-1:0] vaddr_i,
  output logic              l1_accept_o,
  output logic              l1_drop_o,
  output logic              l1_save_o,
  output fault_cause_e      l1_cause_o,
  output logic [ADDR_W-1:0] paddr_o
);

  logic [L1_ENTRIES-1:0] valid_q;
  logic [L1_ENTRIES-1:0] wr_ok_q;
  logic [PAGE_W-1:0]     vpn_q [L1_ENTRIES];
  logic [PAGE_W-1:0]     ppn_q [L1_ENTRIES];
  logic                  wr_en;
  logic                  hit;
  logic                  hit_wr_ok;
  logic [PAGE_W-1:0]     hit_ppn;

  // indices 4 and up never compare equal below, so they fall through
  assign wr_en = cfg_we_i & ~cfg_l2_i;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      valid_q <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < L1_ENTRIES; i++) begin
        if (cfg_idx_i == IDX_W'(i)) begin
          valid_q[i] <= cfg_valid_i;
        end
      end
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (wr_en) begin
      for (int i = 0; i < L1_ENTRIES; i++) begin
        if (cfg_idx_i == IDX_W'(i)) begin
          vpn_q[i]   <= cfg_vpn_i;
          ppn_q[i]   <= cfg_ppn_i;
          wr_ok_q[i] <= cfg_wr_ok_i;
        end
      end
    end
  end

  // parallel compare, the lowest index wins when a page is mapped twice
  always_comb begin
    hit       = 1'b0;
    hit_wr_ok = 1'b0;
    hit_ppn   = '0;
    for (int i = L1_ENTRIES - 1; i >= 0; i--) begin
      if (valid_q[i] && (vpn_q[i] == vaddr_i[ADDR_W-1:OFFS_W])) begin
        hit       = 1'b1;
        hit_wr_ok = wr_ok_q[i];
        hit_ppn   = ppn_q[i];
      end
    end
  end

  // exactly one of accept, drop and save is high for any address
  assign l1_accept_o = hit & hit_wr_ok;
  assign l1_drop_o   = (hit & ~hit_wr_ok) | (~hit & ~ENABLE_L2TLB);
  assign l1_save_o   = ~hit & ENABLE_L2TLB;
  assign l1_cause_o  = hit ? FLT_L1_PROT : FLT_L1_MISS;
  assign paddr_o     = {hit_ppn, vaddr_i[OFFS_W-1:0]};

endmodule

//--- source/rab_l2_tlb.sv
`timescale 1ns/10ps

module rab_l2_tlb
  import rab_pkg::*;
(
  input  logic              axi4_aclk,
  input  logic              axi4_arstn,
  input  logic              cfg_we_i,
  input  logic              cfg_l2_i,
  input  logic [IDX_W-1:0]  cfg_idx_i,
  input  logic [PAGE_W-1:0] cfg_vpn_i,
  input  logic [PAGE_W-1:0] cfg_ppn_i,
  input  logic              cfg_wr_ok_i,
  input  logic              cfg_valid_i,
  input  logic              l1_done_i,
  input  logic              l1_save_i,
  input  logic [ADDR_W-1:0] vaddr_i,
  input  logic              l2_done_i,
  output logic              l2_accept_o,
  output logic              l2_drop_o,
  output fault_cause_e      l2_cause_o,
  output logic [ADDR_W-1:0] l2_awaddr_o,
  output logic [ADDR_W-1:0] l2_vaddr_o
);

  typedef enum logic [1:0] {
    L2_IDLE,
    L2_SEARCH,
    L2_HOLD
  } state_e;

  logic [L2_ENTRIES-1:0] valid_q;
  logic [L2_ENTRIES-1:0] wr_ok_q;
  logic [PAGE_W-1:0]     vpn_q [L2_ENTRIES];
  logic [PAGE_W-1:0]     ppn_q [L2_ENTRIES];
  state_e                state_q;
  logic [IDX_W-1:0]      idx_q;
  logic [ADDR_W-1:0]     vaddr_q;
  logic [PAGE_W-1:0]     ppn_hold_q;
  logic                  wr_en;
  logic                  start;
  logic                  cur_hit;
  logic                  last;

  assign wr_en = cfg_we_i & cfg_l2_i;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[cfg_idx_i] <= cfg_valid_i;
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (wr_en) begin
      vpn_q[cfg_idx_i]   <= cfg_vpn_i;
      ppn_q[cfg_idx_i]   <= cfg_ppn_i;
      wr_ok_q[cfg_idx_i] <= cfg_wr_ok_i;
    end
  end

  // the slot is only ever free while this FSM idles
  assign start   = (state_q == L2_IDLE) & l1_done_i & l1_save_i;
  assign cur_hit = valid_q[idx_q] & (vpn_q[idx_q] == vaddr_q[ADDR_W-1:OFFS_W]);
  assign last    = (idx_q == IDX_W'(L2_ENTRIES - 1));

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q <= L2_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        L2_IDLE: begin
          if (start) begin
            state_q <= L2_SEARCH;
            idx_q   <= '0;
          end
        end
        L2_SEARCH: begin
          if (l2_accept_o) begin
            state_q <= l2_done_i ? L2_IDLE : L2_HOLD;
          end else if (l2_drop_o) begin
            state_q <= L2_IDLE;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
        L2_HOLD: begin
          if (l2_done_i) begin
            state_q <= L2_IDLE;
          end
        end
        default: state_q <= L2_IDLE;
      endcase
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (start) begin
      vaddr_q <= vaddr_i;
    end
    // keeps the translation steady while the master side stalls
    if (state_q == L2_SEARCH) begin
      ppn_hold_q <= ppn_q[idx_q];
    end
  end

  // a result is offered in the very cycle its entry is compared
  assign l2_accept_o = (state_q == L2_HOLD) |
                       ((state_q == L2_SEARCH) & cur_hit & wr_ok_q[idx_q]);
  assign l2_drop_o   = (state_q == L2_SEARCH) &
                       ((cur_hit & ~wr_ok_q[idx_q]) | (~cur_hit & last));
  assign l2_cause_o  = cur_hit ? FLT_L2_PROT : FLT_L2_MISS;
  assign l2_awaddr_o = {(state_q == L2_HOLD) ? ppn_hold_q : ppn_q[idx_q],
                        vaddr_q[OFFS_W-1:0]};
  assign l2_vaddr_o  = vaddr_q;

endmodule

//--- source/axi4_aw_sender.sv
`timescale 1ns/10ps

module axi4_aw_sender
  import rab_pkg::*;
#(
  parameter bit ENABLE_L2TLB = 1'b1
) (
  input  logic               axi4_aclk,
  input  logic               axi4_arstn,
  input  logic               l1_accept_i,
  input  logic               l1_drop_i,
  input  logic               l1_save_i,
  input  logic               l2_accept_i,
  input  logic               l2_drop_i,
  input  logic [ADDR_W-1:0]  l1_awaddr_i,
  input  logic [ADDR_W-1:0]  l2_awaddr_i,
  input  logic [ID_W-1:0]    s_axi4_awid_i,
  input  logic [LEN_W-1:0]   s_axi4_awlen_i,
  input  logic [SIZE_W-1:0]  s_axi4_awsize_i,
  input  logic [BURST_W-1:0] s_axi4_awburst_i,
  input  logic [PROT_W-1:0]  s_axi4_awprot_i,
  input  logic [USER_W-1:0]  s_axi4_awuser_i,
  input  logic               s_axi4_awvalid_i,
  input  logic               m_axi4_awready_i,
  output logic               l1_done_o,
  output logic               l2_done_o,
  output logic               l2_sending_o,
  output logic               s_axi4_awready_o,
  output logic [ID_W-1:0]    m_axi4_awid_o,
  output logic [ADDR_W-1:0]  m_axi4_awaddr_o,
  output logic [LEN_W-1:0]   m_axi4_awlen_o,
  output logic [SIZE_W-1:0]  m_axi4_awsize_o,
  output logic [BURST_W-1:0] m_axi4_awburst_o,
  output logic [PROT_W-1:0]  m_axi4_awprot_o,
  output logic [USER_W-1:0]  m_axi4_awuser_o,
  output logic               m_axi4_awvalid_o
);

  logic l1_save_ok;
  logic l2_avail_q;

  // a miss is only taken while the single L2 slot is free
  assign l1_save_ok = l1_save_i & l2_avail_q;
  assign l1_done_o  = s_axi4_awvalid_i & s_axi4_awready_o;

  assign m_axi4_awvalid_o = (s_axi4_awvalid_i & l1_accept_i) | l2_sending_o;
  assign s_axi4_awready_o = (m_axi4_awvalid_o & m_axi4_awready_i & ~l2_sending_o) |
                            (s_axi4_awvalid_i & (l1_drop_i | l1_save_ok));

  if (ENABLE_L2TLB) begin : gen_l2
    logic [ID_W-1:0]    l2_id_q;
    logic [LEN_W-1:0]   l2_len_q;
    logic [SIZE_W-1:0]  l2_size_q;
    logic [BURST_W-1:0] l2_burst_q;
    logic [PROT_W-1:0]  l2_prot_q;
    logic [USER_W-1:0]  l2_user_q;
    logic               hold_l1_q;
    logic               l2_sent;

    assign m_axi4_awid_o    = l2_sending_o ? l2_id_q     : s_axi4_awid_i;
    assign m_axi4_awaddr_o  = l2_sending_o ? l2_awaddr_i : l1_awaddr_i;
    assign m_axi4_awlen_o   = l2_sending_o ? l2_len_q    : s_axi4_awlen_i;
    assign m_axi4_awsize_o  = l2_sending_o ? l2_size_q   : s_axi4_awsize_i;
    assign m_axi4_awburst_o = l2_sending_o ? l2_burst_q  : s_axi4_awburst_i;
    assign m_axi4_awprot_o  = l2_sending_o ? l2_prot_q   : s_axi4_awprot_i;
    assign m_axi4_awuser_o  = l2_sending_o ? l2_user_q   : s_axi4_awuser_i;

    // copy of the missing request, sent later with the L2 address
    always_ff @(posedge axi4_aclk) begin
      if (l1_done_o && l1_save_ok) begin
        l2_id_q    <= s_axi4_awid_i;
        l2_len_q   <= s_axi4_awlen_i;
        l2_size_q  <= s_axi4_awsize_i;
        l2_burst_q <= s_axi4_awburst_i;
        l2_prot_q  <= s_axi4_awprot_i;
        l2_user_q  <= s_axi4_awuser_i;
      end
    end

    always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
      if (!axi4_arstn) begin
        l2_avail_q <= 1'b1;
        hold_l1_q  <= 1'b0;
      end else begin
        if (l2_done_o) begin
          l2_avail_q <= 1'b1;
        end else if (l1_done_o && l1_save_ok) begin
          l2_avail_q <= 1'b0;
        end
        // an L1 hit already on the master side keeps the bus until taken
        hold_l1_q <= m_axi4_awvalid_o & ~m_axi4_awready_i & ~l2_sending_o;
      end
    end

    assign l2_sending_o = l2_accept_i & ~l2_avail_q & ~hold_l1_q;
    assign l2_sent      = l2_sending_o & m_axi4_awready_i;
    assign l2_done_o    = l2_sent | l2_drop_i;

  end else begin : gen_no_l2
    assign m_axi4_awid_o    = s_axi4_awid_i;
    assign m_axi4_awaddr_o  = l1_awaddr_i;
    assign m_axi4_awlen_o   = s_axi4_awlen_i;
    assign m_axi4_awsize_o  = s_axi4_awsize_i;
    assign m_axi4_awburst_o = s_axi4_awburst_i;
    assign m_axi4_awprot_o  = s_axi4_awprot_i;
    assign m_axi4_awuser_o  = s_axi4_awuser_i;

    assign l2_avail_q   = 1'b0;
    assign l2_sending_o = 1'b0;
    assign l2_done_o    = 1'b0;
  end

endmodule

//--- source/rab_fault_log.sv
`timescale 1ns/10ps

module rab_fault_log
  import rab_pkg::*;
(
  input  logic              axi4_aclk,
  input  logic              axi4_arstn,
  input  logic              l1_done_i,
  input  logic              l1_drop_i,
  input  fault_cause_e      l1_cause_i,
  input  logic [ADDR_W-1:0] l1_vaddr_i,
  input  logic              l2_drop_i,
  input  fault_cause_e      l2_cause_i,
  input  logic [ADDR_W-1:0] l2_vaddr_i,
  output logic [7:0]        fault_count_o,
  output fault_cause_e      fault_cause_o,
  output logic [ADDR_W-1:0] fault_addr_o
);

  logic       l1_fault;
  logic [1:0] n_new;
  logic [8:0] sum;

  assign l1_fault = l1_done_i & l1_drop_i;

  // both faults of one cycle are counted, only the L2 one is recorded
  assign n_new = {1'b0, l1_fault} + {1'b0, l2_drop_i};
  assign sum   = {1'b0, fault_count_o} + {7'd0, n_new};

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      fault_count_o <= '0;
      fault_cause_o <= FLT_L1_PROT;
      fault_addr_o  <= '0;
    end else begin
      fault_count_o <= sum[8] ? 8'hff : sum[7:0];
      if (l2_drop_i) begin
        fault_cause_o <= l2_cause_i;
        fault_addr_o  <= l2_vaddr_i;
      end else if (l1_fault) begin
        fault_cause_o <= l1_cause_i;
        fault_addr_o  <= l1_vaddr_i;
      end
    end
  end

endmodule

//--- source/rab_aw_top.sv
`timescale 1ns/10ps

module rab_aw_top
  import rab_pkg::*;
#(
  parameter bit ENABLE_L2TLB = 1'b1
) (
  input  logic               axi4_aclk,
  input  logic               axi4_arstn,
  input  logic               cfg_we_i,
  input  logic               cfg_l2_i,
  input  logic [IDX_W-1:0]   cfg_idx_i,
  input  logic [PAGE_W-1:0]  cfg_vpn_i,
  input  logic [PAGE_W-1:0]  cfg_ppn_i,
  input  logic               cfg_wr_ok_i,
  input  logic               cfg_valid_i,
  input  logic [ID_W-1:0]    s_axi4_awid_i,
  input  logic [ADDR_W-1:0]  s_axi4_awaddr_i,
  input  logic [LEN_W-1:0]   s_axi4_awlen_i,
  input  logic [SIZE_W-1:0]  s_axi4_awsize_i,
  input  logic [BURST_W-1:0] s_axi4_awburst_i,
  input  logic [PROT_W-1:0]  s_axi4_awprot_i,
  input  logic [USER_W-1:0]  s_axi4_awuser_i,
  input  logic               s_axi4_awvalid_i,
  output logic               s_axi4_awready_o,
  output logic [ID_W-1:0]    m_axi4_awid_o,
  output logic [ADDR_W-1:0]  m_axi4_awaddr_o,
  output logic [LEN_W-1:0]   m_axi4_awlen_o,
  output logic [SIZE_W-1:0]  m_axi4_awsize_o,
  output logic [BURST_W-1:0] m_axi4_awburst_o,
  output logic [PROT_W-1:0]  m_axi4_awprot_o,
  output logic [USER_W-1:0]  m_axi4_awuser_o,
  output logic               m_axi4_awvalid_o,
  input  logic               m_axi4_awready_i,
  output logic [7:0]         fault_count_o,
  output fault_cause_e       fault_cause_o,
  output logic [ADDR_W-1:0]  fault_addr_o
);

  logic              l1_accept;
  logic              l1_drop;
  logic              l1_save;
  fault_cause_e      l1_cause;
  logic [ADDR_W-1:0] l1_awaddr;
  logic              l1_done;
  logic              l2_accept;
  logic              l2_drop;
  fault_cause_e      l2_cause;
  logic [ADDR_W-1:0] l2_awaddr;
  logic [ADDR_W-1:0] l2_vaddr;
  logic              l2_done;

  rab_l1_tlb #(
    .ENABLE_L2TLB(ENABLE_L2TLB)
  ) rab_l1_tlb_inst (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .cfg_we_i   (cfg_we_i),
    .cfg_l2_i   (cfg_l2_i),
    .cfg_idx_i  (cfg_idx_i),
    .cfg_vpn_i  (cfg_vpn_i),
    .cfg_ppn_i  (cfg_ppn_i),
    .cfg_wr_ok_i(cfg_wr_ok_i),
    .cfg_valid_i(cfg_valid_i),
    .vaddr_i    (s_axi4_awaddr_i),
    .l1_accept_o(l1_accept),
    .l1_drop_o  (l1_drop),
    .l1_save_o  (l1_save),
    .l1_cause_o (l1_cause),
    .paddr_o    (l1_awaddr)
  );

  if (ENABLE_L2TLB) begin : gen_l2_tlb
    rab_l2_tlb rab_l2_tlb_inst (
      .axi4_aclk  (axi4_aclk),
      .axi4_arstn (axi4_arstn),
      .cfg_we_i   (cfg_we_i),
      .cfg_l2_i   (cfg_l2_i),
      .cfg_idx_i  (cfg_idx_i),
      .cfg_vpn_i  (cfg_vpn_i),
      .cfg_ppn_i  (cfg_ppn_i),
      .cfg_wr_ok_i(cfg_wr_ok_i),
      .cfg_valid_i(cfg_valid_i),
      .l1_done_i  (l1_done),
      .l1_save_i  (l1_save),
      .vaddr_i    (s_axi4_awaddr_i),
      .l2_done_i  (l2_done),
      .l2_accept_o(l2_accept),
      .l2_drop_o  (l2_drop),
      .l2_cause_o (l2_cause),
      .l2_awaddr_o(l2_awaddr),
      .l2_vaddr_o (l2_vaddr)
    );
  end else begin : gen_no_l2_tlb
    assign l2_accept = 1'b0;
    assign l2_drop   = 1'b0;
    assign l2_cause  = FLT_L2_MISS;
    assign l2_awaddr = '0;
    assign l2_vaddr  = '0;
  end

  axi4_aw_sender #(
    .ENABLE_L2TLB(ENABLE_L2TLB)
  ) axi4_aw_sender_inst (
    .axi4_aclk       (axi4_aclk),
    .axi4_arstn      (axi4_arstn),
    .l1_accept_i     (l1_accept),
    .l1_drop_i       (l1_drop),
    .l1_save_i       (l1_save),
    .l2_accept_i     (l2_accept),
    .l2_drop_i       (l2_drop),
    .l1_awaddr_i     (l1_awaddr),
    .l2_awaddr_i     (l2_awaddr),
    .s_axi4_awid_i   (s_axi4_awid_i),
    .s_axi4_awlen_i  (s_axi4_awlen_i),
    .s_axi4_awsize_i (s_axi4_awsize_i),
    .s_axi4_awburst_i(s_axi4_awburst_i),
    .s_axi4_awprot_i (s_axi4_awprot_i),
    .s_axi4_awuser_i (s_axi4_awuser_i),
    .s_axi4_awvalid_i(s_axi4_awvalid_i),
    .m_axi4_awready_i(m_axi4_awready_i),
    .l1_done_o       (l1_done),
    .l2_done_o       (l2_done),
    .l2_sending_o    (),
    .s_axi4_awready_o(s_axi4_awready_o),
    .m_axi4_awid_o   (m_axi4_awid_o),
    .m_axi4_awaddr_o (m_axi4_awaddr_o),
    .m_axi4_awlen_o  (m_axi4_awlen_o),
    .m_axi4_awsize_o (m_axi4_awsize_o),
    .m_axi4_awburst_o(m_axi4_awburst_o),
    .m_axi4_awprot_o (m_axi4_awprot_o),
    .m_axi4_awuser_o (m_axi4_awuser_o),
    .m_axi4_awvalid_o(m_axi4_awvalid_o)
  );

  rab_fault_log rab_fault_log_inst (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .l1_done_i    (l1_done),
    .l1_drop_i    (l1_drop),
    .l1_cause_i   (l1_cause),
    .l1_vaddr_i   (s_axi4_awaddr_i),
    .l2_drop_i    (l2_drop),
    .l2_cause_i   (l2_cause),
    .l2_vaddr_i   (l2_vaddr),
    .fault_count_o(fault_count_o),
    .fault_cause_o(fault_cause_o),
    .fault_addr_o (fault_addr_o)
  );

endmodule

//--- tb/rab_aw_assert.sv
`timescale 1ns/10ps

module rab_aw_assert
  import rab_pkg::*;
(
  input logic                                                        axi4_aclk,
  input logic                                                        axi4_arstn,
  input logic                                                        m_awvalid_i,
  input logic                                                        m_awready_i,
  input logic [ID_W+ADDR_W+LEN_W+SIZE_W+BURST_W+PROT_W+USER_W-1:0] m_aw_fields_i,
  input logic                                                        l1_done_i,
  input logic                                                        l1_save_i,
  input logic                                                        l2_avail_i,
  input logic                                                        l2_accept_i,
  input logic                                                        l2_drop_i
);

  // number of failed assertions, watched by the testbench
  int fail_count = 0;

  // a stalled master request keeps valid and every field until ready
  master_stable: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    m_awvalid_i && !m_awready_i |=> m_awvalid_i && $stable(m_aw_fields_i))
    else begin
      $error("master AW request changed before ready");
      fail_count++;
    end

  // the single L2 slot takes a miss only when it is free
  save_needs_free_slot: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    l1_done_i && l1_save_i |-> l2_avail_i)
    else begin
      $error("miss saved while the L2 slot was occupied");
      fail_count++;
    end

  // the L2 TLB only offers a result while the slot holds a saved request
  result_needs_busy_slot: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    l2_accept_i || l2_drop_i |-> !l2_avail_i)
    else begin
      $error("L2 result offered while the slot was free");
      fail_count++;
    end

endmodule

bind axi4_aw_sender rab_aw_assert rab_aw_assert_inst (
  .axi4_aclk    (axi4_aclk),
  .axi4_arstn   (axi4_arstn),
  .m_awvalid_i  (m_axi4_awvalid_o),
  .m_awready_i  (m_axi4_awready_i),
  .m_aw_fields_i({m_axi4_awid_o, m_axi4_awaddr_o, m_axi4_awlen_o, m_axi4_awsize_o,
                  m_axi4_awburst_o, m_axi4_awprot_o, m_axi4_awuser_o}),
  .l1_done_i    (l1_done_o),
  .l1_save_i    (l1_save_i),
  .l2_avail_i   (l2_avail_q),
  .l2_accept_i  (l2_accept_i),
  .l2_drop_i    (l2_drop_i)
);

//--- tb/rab_aw_tb.sv
`timescale 1ns/10ps

module rab_aw_tb
  import rab_pkg::*;
();

  localparam int N_CFG   = 8;
  localparam int N_REQ   = 12;
  localparam int TIMEOUT = 200;

  typedef struct {
    logic              l2;
    logic [IDX_W-1:0]  idx;
    logic [PAGE_W-1:0] vpn;
    logic [PAGE_W-1:0] ppn;
    logic              wr_ok;
    logic              valid;
  } cfg_row_t;

  // cause is only looked at for rows that are not forwarded
  typedef struct {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
    logic [PROT_W-1:0]  prot;
    logic [USER_W-1:0]  user;
    logic               fwd;
    logic [ADDR_W-1:0]  exp_addr;
    fault_cause_e       cause;
  } req_row_t;

  cfg_row_t cfg_tbl [N_CFG] = '{
    '{1'b0, 3'd0, 20'h00010, 20'h80010, 1'b1, 1'b1},
    '{1'b0, 3'd1, 20'h00011, 20'h80011, 1'b0, 1'b1},
    '{1'b0, 3'd2, 20'h00012, 20'ha0012, 1'b1, 1'b1},
    // index 4 lies outside L1, so page 0x00030 stays an L1 miss
    '{1'b0, 3'd4, 20'h00030, 20'h90030, 1'b1, 1'b1},
    '{1'b1, 3'd0, 20'h00020, 20'hc0020, 1'b1, 1'b1},
    '{1'b1, 3'd3, 20'h00021, 20'hc0021, 1'b0, 1'b1},
    '{1'b1, 3'd5, 20'h00030, 20'hc0030, 1'b1, 1'b1},
    '{1'b1, 3'd7, 20'h00022, 20'hc0022, 1'b1, 1'b1}
  };

  req_row_t req_tbl [N_REQ] = '{
    '{4'd1,  32'h0001_0abc, 8'd3,   3'd2, 2'd1, 3'd0, 4'h1, 1'b1, 32'h8001_0abc, FLT_L1_PROT},
    '{4'd2,  32'h0001_1100, 8'd0,   3'd2, 2'd1, 3'd2, 4'h2, 1'b0, 32'h0,         FLT_L1_PROT},
    '{4'd3,  32'h0002_0010, 8'd7,   3'd3, 2'd1, 3'd1, 4'h3, 1'b1, 32'hc002_0010, FLT_L1_PROT},
    '{4'd4,  32'h0002_2ff0, 8'd1,   3'd2, 2'd2, 3'd0, 4'h4, 1'b1, 32'hc002_2ff0, FLT_L1_PROT},
    '{4'd5,  32'h0001_2004, 8'd15,  3'd2, 2'd1, 3'd3, 4'h5, 1'b1, 32'ha001_2004, FLT_L1_PROT},
    '{4'd6,  32'h0002_1008, 8'd0,   3'd0, 2'd0, 3'd0, 4'h6, 1'b0, 32'h0,         FLT_L2_PROT},
    '{4'd7,  32'h0004_0000, 8'd2,   3'd1, 2'd1, 3'd4, 4'h7, 1'b0, 32'h0,         FLT_L2_MISS},
    '{4'd8,  32'h0003_0040, 8'd4,   3'd2, 2'd1, 3'd5, 4'h8, 1'b1, 32'hc003_0040, FLT_L1_PROT},
    '{4'd9,  32'h0001_0ffc, 8'd0,   3'd2, 2'd0, 3'd6, 4'h9, 1'b1, 32'h8001_0ffc, FLT_L1_PROT},
    '{4'd10, 32'h0002_0abc, 8'd255, 3'd2, 2'd1, 3'd7, 4'ha, 1'b1, 32'hc002_0abc, FLT_L1_PROT},
    '{4'd11, 32'h0005_5000, 8'd1,   3'd2, 2'd1, 3'd0, 4'hb, 1'b0, 32'h0,         FLT_L2_MISS},
    '{4'd12, 32'h0001_1ffc, 8'd0,   3'd2, 2'd1, 3'd1, 4'hc, 1'b0, 32'h0,         FLT_L1_PROT}
  };

  logic               axi4_aclk;
  logic               axi4_arstn;
  logic               cfg_we_i;
  logic               cfg_l2_i;
  logic [IDX_W-1:0]   cfg_idx_i;
  logic [PAGE_W-1:0]  cfg_vpn_i;
  logic [PAGE_W-1:0]  cfg_ppn_i;
  logic               cfg_wr_ok_i;
  logic               cfg_valid_i;
  logic [ID_W-1:0]    s_axi4_awid_i;
  logic [ADDR_W-1:0]  s_axi4_awaddr_i;
  logic [LEN_W-1:0]   s_axi4_awlen_i;
  logic [SIZE_W-1:0]  s_axi4_awsize_i;
  logic [BURST_W-1:0] s_axi4_awburst_i;
  logic [PROT_W-1:0]  s_axi4_awprot_i;
  logic [USER_W-1:0]  s_axi4_awuser_i;
  logic               s_axi4_awvalid_i;
  logic               s_axi4_awready_o;
  logic [ID_W-1:0]    m_axi4_awid_o;
  logic [ADDR_W-1:0]  m_axi4_awaddr_o;
  logic [LEN_W-1:0]   m_axi4_awlen_o;
  logic [SIZE_W-1:0]  m_axi4_awsize_o;
  logic [BURST_W-1:0] m_axi4_awburst_o;
  logic [PROT_W-1:0]  m_axi4_awprot_o;
  logic [USER_W-1:0]  m_axi4_awuser_o;
  logic               m_axi4_awvalid_o;
  logic               m_axi4_awready_i;
  logic [7:0]         fault_count_o;
  fault_cause_e       fault_cause_o;
  logic [ADDR_W-1:0]  fault_addr_o;

  logic [31:0] lfsr_q = 32'h9f4f;
  bit          fwd_seen [N_REQ];
  int          n_fwd_seen = 0;
  int          n_fwd_exp = 0;
  int          n_fault_exp = 0;
  int          prev_count = 0;

  rab_aw_top rab_aw_top_inst (.*);

  initial begin
    axi4_aclk = 1'b0;
    forever #20 axi4_aclk = ~axi4_aclk;
  end

  // right-shifting galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [ADDR_W-1:0] got,
                           input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp));
    end
  endtask

  function automatic int find_by_id(input logic [ID_W-1:0] id);
    for (int i = 0; i < N_REQ; i++) begin
      if (req_tbl[i].id == id) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic int find_by_addr(input logic [ADDR_W-1:0] addr);
    for (int i = 0; i < N_REQ; i++) begin
      if (req_tbl[i].addr == addr) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic write_tables();
    for (int i = 0; i < N_CFG; i++) begin
      @(posedge axi4_aclk);
      cfg_we_i    <= 1'b1;
      cfg_l2_i    <= cfg_tbl[i].l2;
      cfg_idx_i   <= cfg_tbl[i].idx;
      cfg_vpn_i   <= cfg_tbl[i].vpn;
      cfg_ppn_i   <= cfg_tbl[i].ppn;
      cfg_wr_ok_i <= cfg_tbl[i].wr_ok;
      cfg_valid_i <= cfg_tbl[i].valid;
    end
    @(posedge axi4_aclk);
    cfg_we_i <= 1'b0;
  endtask

  task automatic drive_request(input req_row_t r);
    s_axi4_awid_i    <= r.id;
    s_axi4_awaddr_i  <= r.addr;
    s_axi4_awlen_i   <= r.len;
    s_axi4_awsize_i  <= r.size;
    s_axi4_awburst_i <= r.burst;
    s_axi4_awprot_i  <= r.prot;
    s_axi4_awuser_i  <= r.user;
    s_axi4_awvalid_i <= 1'b1;
  endtask

  // returns at the falling edge before the rising edge that completes the transfer
  task automatic wait_slave_handshake(input logic [ID_W-1:0] id);
    int cycles = 0;
    do begin
      @(negedge axi4_aclk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("timeout waiting for the slave side to accept id %0d", id));
      end
    end while (!(s_axi4_awvalid_i && s_axi4_awready_o));
  endtask

  task automatic wait_drain();
    int cycles = 0;
    while (n_fwd_seen != n_fwd_exp || fault_count_o != n_fault_exp) begin
      @(negedge axi4_aclk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout waiting for the outstanding requests to be sent or dropped");
      end
    end
  endtask

  // random back-pressure, one LFSR step per ready bit
  always @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      m_axi4_awready_i <= 1'b0;
    end else begin
      m_axi4_awready_i <= lfsr_q[0];
      lfsr_q           <= lfsr_step(lfsr_q);
    end
  end

  // scoreboard of forwarded requests, matched by id
  always @(negedge axi4_aclk) begin : fwd_monitor
    int i;
    if (axi4_arstn && m_axi4_awvalid_o && m_axi4_awready_i) begin
      i = find_by_id(m_axi4_awid_o);
      if (i < 0 || !req_tbl[i].fwd) begin
        abort_run($sformatf("id %0d was forwarded but should not be", m_axi4_awid_o));
      end else if (fwd_seen[i]) begin
        abort_run($sformatf("id %0d was forwarded twice", m_axi4_awid_o));
      end else begin
        check_val("m_axi4_awaddr_o", m_axi4_awaddr_o, req_tbl[i].exp_addr);
        check_val("m_axi4_awlen_o", m_axi4_awlen_o, req_tbl[i].len);
        check_val("m_axi4_awsize_o", m_axi4_awsize_o, req_tbl[i].size);
        check_val("m_axi4_awburst_o", m_axi4_awburst_o, req_tbl[i].burst);
        check_val("m_axi4_awprot_o", m_axi4_awprot_o, req_tbl[i].prot);
        check_val("m_axi4_awuser_o", m_axi4_awuser_o, req_tbl[i].user);
        fwd_seen[i] = 1'b1;
        n_fwd_seen++;
      end
    end
  end

  // each new fault record must name a faulting request with its cause
  always @(negedge axi4_aclk) begin : fault_monitor
    int i;
    if (axi4_arstn && fault_count_o != prev_count) begin
      i = find_by_addr(fault_addr_o);
      if (i < 0 || req_tbl[i].fwd) begin
        abort_run($sformatf("fault log records address 0x%0h, which should not fault",
                            fault_addr_o));
      end else begin
        check_val("fault_cause_o", fault_cause_o, req_tbl[i].cause);
        prev_count = fault_count_o;
      end
    end
  end

  // protocol assertions bound into the sender
  always @(negedge axi4_aclk) begin
    if (rab_aw_top_inst.axi4_aw_sender_inst.rab_aw_assert_inst.fail_count != 0) begin
      abort_run("a bound AXI protocol assertion failed");
    end
  end

  initial begin : main
    axi4_arstn       = 1'b0;
    cfg_we_i         = 1'b0;
    cfg_l2_i         = 1'b0;
    cfg_idx_i        = '0;
    cfg_vpn_i        = '0;
    cfg_ppn_i        = '0;
    cfg_wr_ok_i      = 1'b0;
    cfg_valid_i      = 1'b0;
    s_axi4_awid_i    = '0;
    s_axi4_awaddr_i  = '0;
    s_axi4_awlen_i   = '0;
    s_axi4_awsize_i  = '0;
    s_axi4_awburst_i = '0;
    s_axi4_awprot_i  = '0;
    s_axi4_awuser_i  = '0;
    s_axi4_awvalid_i = 1'b0;
    m_axi4_awready_i = 1'b0;
    for (int i = 0; i < N_REQ; i++) begin
      if (req_tbl[i].fwd) begin
        n_fwd_exp++;
      end else begin
        n_fault_exp++;
      end
    end
    repeat (2) @(posedge axi4_aclk);
    axi4_arstn <= 1'b1;
    write_tables();
    // requests go back to back, so a new miss often meets a busy slot
    for (int k = 0; k < N_REQ; k++) begin
      @(posedge axi4_aclk);
      drive_request(req_tbl[k]);
      wait_slave_handshake(req_tbl[k].id);
    end
    @(posedge axi4_aclk);
    s_axi4_awvalid_i <= 1'b0;
    wait_drain();
    repeat (10) @(negedge axi4_aclk);
    check_val("fault_count_o", fault_count_o, n_fault_exp);
    if (rab_aw_top_inst.axi4_aw_sender_inst.rab_aw_assert_inst.fail_count != 0) begin
      abort_run("the bound AXI protocol assertions reported errors");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- rab_aw_top.f
source/rab_pkg.sv
source/rab_l1_tlb.sv
source/rab_l2_tlb.sv
source/axi4_aw_sender.sv
source/rab_fault_log.sv
source/rab_aw_top.sv
tb/rab_aw_assert.sv
tb/rab_aw_tb.sv
